// File: hw/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  // ----------------------------------------
  // Machine width and reset vector
  // ----------------------------------------
  localparam int unsigned XLEN = 32;

  // First fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // ----------------------------------------
  // Major opcodes, instr[6:0]
  // ----------------------------------------
  typedef enum logic [6:0] {
    R_TYPE     = 7'b0110011,
    I_TYPE     = 7'b0010011,
    L_TYPE     = 7'b0000011,
    S_TYPE     = 7'b0100011,
    B_TYPE     = 7'b1100011,
    U_TYPE     = 7'b0110111,
    AUIPC_TYPE = 7'b0010111,
    JAL_TYPE   = 7'b1101111,
    JALR_TYPE  = 7'b1100111,
    P_TYPE     = 7'b1110011,
    FENCE_TYPE = 7'b0001111
  } opcode_e;

  // funct7 values seen on OP and OP-IMM shifts
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // ALU funct3, shared by register and immediate forms
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Conditional branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

  // ----------------------------------------
  // Decode encodings
  // ----------------------------------------
  typedef enum logic [2:0] {
    UNIT_ALU,
    UNIT_SHIFT,
    UNIT_BRANCH,
    UNIT_LSU,
    UNIT_MULDIV,
    UNIT_SYSTEM
  } unit_e;

  typedef enum logic [4:0] {
    // ALU
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU, OP_LUI, OP_AUIPC,
    // Shifter
    OP_SLL, OP_SRL, OP_SRA,
    // Branch unit, jumps included
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JAL, OP_JALR,
    // LSU
    OP_LOAD, OP_STORE,
    // Mul/div, variant is in funct3 of the original word
    OP_MUL, OP_DIV,
    // System
    OP_CSR, OP_ECALL, OP_EBREAK, OP_FENCE
  } op_e;

  // Same code as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    ACC_BYTE = 2'b00,
    ACC_HALF = 2'b01,
    ACC_WORD = 2'b10
  } access_e;

  // ----------------------------------------
  // Pipeline packets
  // ----------------------------------------
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } fetch_pkt_t;

  typedef struct packed {
    unit_e       unit;
    op_e         op;
    logic [4:0]  rd;
    logic        rd_v;
    logic [4:0]  rs1;
    logic        rs1_v;
    logic [4:0]  rs2;
    logic        rs2_v;
    logic        op2_is_imm;
    logic [31:0] imm;
    access_e     access;
    logic        unsigned_ext;
    logic        illegal;
  } decode_t;

  typedef struct packed {
    logic [31:0] pc;
    decode_t     dec;
    logic [31:0] rs1_val;
    logic [31:0] op2_val;   // immediate or rs2 value
  } issue_pkt_t;

endpackage

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic        clk_i,
  input  logic [4:0]  raddr1_i,
  input  logic [4:0]  raddr2_i,
  output logic [31:0] rdata1_o,
  output logic [31:0] rdata2_o,
  input  logic        we_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i
);

  // x1..x31 only, x0 has no storage
  logic [31:0] regs_q [1:31];

  always_ff @(posedge clk_i) begin
    if (we_i && (waddr_i != 5'd0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Async read, a write in the same cycle shows up next cycle
  assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs_q[raddr1_i];
  assign rdata2_o = (raddr2_i == 5'd0) ? 32'd0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

// File: hw/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
  input  logic [riscv_pkg::XLEN-1:0] instr_i,
  output core_pkg::decode_t          dec_o
);

  riscv_pkg::opcode_e opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [31:0]        imm_i;
  logic [31:0]        imm_s;
  logic [31:0]        imm_b;
  logic [31:0]        imm_u;
  logic [31:0]        imm_j;

  // OP and OP-IMM share this funct3 map
  function automatic core_pkg::op_e alu_op(input logic [2:0] f3, input logic alt);
    case (f3)
      riscv_pkg::F3_ADD:  alu_op = alt ? core_pkg::OP_SUB : core_pkg::OP_ADD;
      riscv_pkg::F3_SLL:  alu_op = core_pkg::OP_SLL;
      riscv_pkg::F3_SLT:  alu_op = core_pkg::OP_SLT;
      riscv_pkg::F3_SLTU: alu_op = core_pkg::OP_SLTU;
      riscv_pkg::F3_XOR:  alu_op = core_pkg::OP_XOR;
      riscv_pkg::F3_SR:   alu_op = alt ? core_pkg::OP_SRA : core_pkg::OP_SRL;
      riscv_pkg::F3_OR:   alu_op = core_pkg::OP_OR;
      riscv_pkg::F3_AND:  alu_op = core_pkg::OP_AND;
    endcase
  endfunction

  assign opcode = riscv_pkg::opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // ----------------------------------------
  // Immediate formats
  // ----------------------------------------
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'd0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    dec_o     = '0;
    dec_o.rd  = instr_i[11:7];
    dec_o.rs1 = instr_i[19:15];
    dec_o.rs2 = instr_i[24:20];
    case (opcode)
      riscv_pkg::R_TYPE: begin
        dec_o.rd_v  = 1'b1;
        dec_o.rs1_v = 1'b1;
        dec_o.rs2_v = 1'b1;
        if (funct7 == riscv_pkg::F7_MULDIV) begin
          dec_o.unit         = core_pkg::UNIT_MULDIV;
          dec_o.op           = funct3[2] ? core_pkg::OP_DIV : core_pkg::OP_MUL;
          // divu/remu, or mulhu
          dec_o.unsigned_ext = funct3[2] ? funct3[0] : (funct3[1:0] == 2'b11);
        end else if (funct7 == riscv_pkg::F7_BASE || (funct7 == riscv_pkg::F7_ALT &&
                     funct3 inside {riscv_pkg::F3_ADD, riscv_pkg::F3_SR})) begin
          dec_o.op = alu_op(funct3, funct7[5]);
        end else begin
          dec_o.illegal = 1'b1;
        end
      end
      riscv_pkg::I_TYPE: begin
        dec_o.rd_v       = 1'b1;
        dec_o.rs1_v      = 1'b1;
        dec_o.op2_is_imm = 1'b1;
        dec_o.imm        = imm_i;
        dec_o.op         = alu_op(funct3, funct3 == riscv_pkg::F3_SR && funct7[5]);
        // shamt forms keep funct7 in the upper immediate bits
        dec_o.illegal    = (funct3 == riscv_pkg::F3_SLL && funct7 != riscv_pkg::F7_BASE) ||
                           (funct3 == riscv_pkg::F3_SR &&
                            !(funct7 inside {riscv_pkg::F7_BASE, riscv_pkg::F7_ALT}));
      end
      riscv_pkg::L_TYPE: begin
        dec_o.unit         = core_pkg::UNIT_LSU;
        dec_o.op           = core_pkg::OP_LOAD;
        dec_o.rd_v         = 1'b1;
        dec_o.rs1_v        = 1'b1;
        dec_o.op2_is_imm   = 1'b1;
        dec_o.imm          = imm_i;
        dec_o.access       = core_pkg::access_e'(funct3[1:0]);
        dec_o.unsigned_ext = funct3[2];
        dec_o.illegal      = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
      end
      riscv_pkg::S_TYPE: begin
        dec_o.unit    = core_pkg::UNIT_LSU;
        dec_o.op      = core_pkg::OP_STORE;
        dec_o.rs1_v   = 1'b1;
        dec_o.rs2_v   = 1'b1;
        dec_o.imm     = imm_s;
        dec_o.access  = core_pkg::access_e'(funct3[1:0]);
        dec_o.illegal = funct3[2] || (funct3[1:0] == 2'b11);
      end
      riscv_pkg::B_TYPE: begin
        dec_o.unit         = core_pkg::UNIT_BRANCH;
        dec_o.rs1_v        = 1'b1;
        dec_o.rs2_v        = 1'b1;
        dec_o.imm          = imm_b;
        dec_o.unsigned_ext = funct3[1];
        case (funct3)
          riscv_pkg::F3_BEQ:  dec_o.op = core_pkg::OP_BEQ;
          riscv_pkg::F3_BNE:  dec_o.op = core_pkg::OP_BNE;
          riscv_pkg::F3_BLT:  dec_o.op = core_pkg::OP_BLT;
          riscv_pkg::F3_BGE:  dec_o.op = core_pkg::OP_BGE;
          riscv_pkg::F3_BLTU: dec_o.op = core_pkg::OP_BLTU;
          riscv_pkg::F3_BGEU: dec_o.op = core_pkg::OP_BGEU;
          default:            dec_o.illegal = 1'b1;
        endcase
      end
      riscv_pkg::U_TYPE, riscv_pkg::AUIPC_TYPE: begin
        dec_o.op         = instr_i[5] ? core_pkg::OP_LUI : core_pkg::OP_AUIPC;
        dec_o.rd_v       = 1'b1;
        dec_o.op2_is_imm = 1'b1;
        dec_o.imm        = imm_u;
      end
      riscv_pkg::JAL_TYPE, riscv_pkg::JALR_TYPE: begin
        dec_o.unit       = core_pkg::UNIT_BRANCH;
        dec_o.op         = instr_i[3] ? core_pkg::OP_JAL : core_pkg::OP_JALR;
        dec_o.rd_v       = 1'b1;
        dec_o.rs1_v      = !instr_i[3];
        dec_o.op2_is_imm = 1'b1;
        dec_o.imm        = instr_i[3] ? imm_j : imm_i;
        dec_o.illegal    = !instr_i[3] && (funct3 != 3'b000);
      end
      riscv_pkg::P_TYPE: begin
        dec_o.unit = core_pkg::UNIT_SYSTEM;
        if (funct3 == 3'b000) begin
          dec_o.op      = instr_i[20] ? core_pkg::OP_EBREAK : core_pkg::OP_ECALL;
          dec_o.illegal = (instr_i[31:21] != '0) || (instr_i[19:7] != '0);
        end else begin
          // CSR number rides in imm, uimm forms keep the rs1 field
          dec_o.op         = core_pkg::OP_CSR;
          dec_o.rd_v       = 1'b1;
          dec_o.rs1_v      = !funct3[2];
          dec_o.op2_is_imm = 1'b1;
          dec_o.imm        = {20'd0, instr_i[31:20]};
          dec_o.illegal    = (funct3 == 3'b100);
        end
      end
      riscv_pkg::FENCE_TYPE: begin
        dec_o.unit    = core_pkg::UNIT_SYSTEM;
        dec_o.op      = core_pkg::OP_FENCE;
        dec_o.illegal = (funct3 != 3'b000);
      end
      default: dec_o.illegal = 1'b1;
    endcase

    if (dec_o.op inside {core_pkg::OP_SLL, core_pkg::OP_SRL, core_pkg::OP_SRA}) begin
      dec_o.unit = core_pkg::UNIT_SHIFT;
    end
    if (dec_o.op == core_pkg::OP_SLTU) begin
      dec_o.unsigned_ext = 1'b1;
    end
    // x0 is never a real source
    dec_o.rs1_v = dec_o.rs1_v && (dec_o.rs1 != 5'd0);
    dec_o.rs2_v = dec_o.rs2_v && (dec_o.rs2 != 5'd0);

    if (dec_o.illegal) begin
      dec_o.unit  = core_pkg::UNIT_SYSTEM;
      dec_o.op    = core_pkg::OP_ECALL;
      dec_o.rd_v  = 1'b0;
      dec_o.rs1_v = 1'b0;
      dec_o.rs2_v = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic                       clk_i,
  input  logic                       rst_i,
  output logic                       wb_cyc_o,
  output logic                       wb_stb_o,
  output logic                       wb_we_o,
  output logic [riscv_pkg::XLEN-1:0] wb_adr_o,
  input  logic [riscv_pkg::XLEN-1:0] wb_dat_i,
  input  logic                       wb_ack_i,
  output core_pkg::fetch_pkt_t       fetch_o,
  output logic                       fetch_valid_o,
  input  logic                       fetch_ready_i
);

  // IDLE only right after reset, BUS while a read is open,
  // FULL while the output entry holds a word
  typedef enum logic [1:0] {
    IDLE,
    BUS,
    FULL
  } fetch_state_e;

  fetch_state_e               state_q;
  fetch_state_e               state_d;
  logic [riscv_pkg::XLEN-1:0] pc_q;
  core_pkg::fetch_pkt_t       fetch_q;
  logic                       bus_done;

  assign bus_done = (state_q == BUS) && wb_ack_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: state_d = BUS;
      BUS: begin
        if (wb_ack_i) begin
          state_d = FULL;
        end
      end
      // Next request only once the entry is being taken
      FULL: begin
        if (fetch_ready_i) begin
          state_d = BUS;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      pc_q    <= riscv_pkg::RESET_PC;
    end else begin
      state_q <= state_d;
      if (bus_done) begin
        pc_q <= pc_q + riscv_pkg::XLEN'(4);
      end
    end
  end

  // Word and its address
  always_ff @(posedge clk_i) begin
    if (bus_done) begin
      fetch_q.pc    <= pc_q;
      fetch_q.instr <= wb_dat_i;
    end
  end

  // Classic read cycle, cyc and stb together
  assign wb_cyc_o      = (state_q == BUS);
  assign wb_stb_o      = (state_q == BUS);
  assign wb_we_o       = 1'b0;
  assign wb_adr_o      = pc_q;
  assign fetch_o       = fetch_q;
  assign fetch_valid_o = (state_q == FULL);

endmodule

`default_nettype wire

// File: hw/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  core_pkg::fetch_pkt_t fetch_i,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  input  logic                 rf_we_i,
  input  logic [4:0]           rf_waddr_i,
  input  logic [31:0]          rf_wdata_i,
  output core_pkg::issue_pkt_t issue_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);

  core_pkg::decode_t    dec;
  logic [31:0]          rs1_data;
  logic [31:0]          rs2_data;
  core_pkg::issue_pkt_t issue_d;
  core_pkg::issue_pkt_t issue_q;
  logic                 valid_q;
  logic                 take;

  decoder i_decoder (
    .instr_i (fetch_i.instr),
    .dec_o   (dec)
  );

  reg_file i_reg_file (
    .clk_i    (clk_i),
    .raddr1_i (dec.rs1),
    .raddr2_i (dec.rs2),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data),
    .we_i     (rf_we_i),
    .waddr_i  (rf_waddr_i),
    .wdata_i  (rf_wdata_i)
  );

  // Operand assembly
  always_comb begin
    issue_d.pc      = fetch_i.pc;
    issue_d.dec     = dec;
    issue_d.rs1_val = rs1_data;
    issue_d.op2_val = dec.op2_is_imm ? dec.imm : rs2_data;
  end

  // One output register, refilled as it drains
  assign fetch_ready_o = !valid_q || out_ready_i;
  assign take          = fetch_valid_i && fetch_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (fetch_ready_o) begin
      valid_q <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      issue_q <= issue_d;
    end
  end

  assign issue_o     = issue_q;
  assign out_valid_o = valid_q;

endmodule

`default_nettype wire

// File: hw/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Instruction memory, Wishbone classic
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output logic                 wb_we_o,
  output logic [31:0]          wb_adr_o,
  input  logic [31:0]          wb_dat_i,
  input  logic                 wb_ack_i,
  // Writeback from execute
  input  logic                 rf_we_i,
  input  logic [4:0]           rf_waddr_i,
  input  logic [31:0]          rf_wdata_i,
  // Issue port
  output core_pkg::issue_pkt_t issue_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);

  core_pkg::fetch_pkt_t fetch_pkt;
  logic                 fetch_valid;
  logic                 fetch_ready;

  fetch_stage i_fetch_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_we_o       (wb_we_o),
    .wb_adr_o      (wb_adr_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i),
    .fetch_o       (fetch_pkt),
    .fetch_valid_o (fetch_valid),
    .fetch_ready_i (fetch_ready)
  );

  issue_stage i_issue_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_i       (fetch_pkt),
    .fetch_valid_i (fetch_valid),
    .fetch_ready_o (fetch_ready),
    .rf_we_i       (rf_we_i),
    .rf_waddr_i    (rf_waddr_i),
    .rf_wdata_i    (rf_wdata_i),
    .issue_o       (issue_o),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i)
  );

endmodule

`default_nettype wire

// File: test/frontend_tb_table.svh
`ifndef FRONTEND_TB_TABLE_SVH
`define FRONTEND_TB_TABLE_SVH

// Columns: instr, unit, op, rd, rd_v, op2_is_imm, imm, illegal
typedef struct packed {
  logic [31:0]     instr;
  core_pkg::unit_e unit;
  core_pkg::op_e   op;
  logic [4:0]      rd;
  logic            rd_v;
  logic            op2_is_imm;
  logic [31:0]     imm;
  logic            illegal;
} row_t;

localparam int NUM_ROWS = 23;

// Values written into x1..x8 before the first ack
localparam logic [31:0] RF_INIT [1:8] = '{
  32'h1111_0001, 32'h2222_0002, 32'h3333_0003, 32'h4444_0004,
  32'h5555_0005, 32'h6666_0006, 32'h7777_0007, 32'h8888_0008
};

localparam row_t ROWS [NUM_ROWS] = '{
  '{32'h002081B3, core_pkg::UNIT_ALU,    core_pkg::OP_ADD,    5'd3,  1'b1, 1'b0, 32'h0, 1'b0},
  '{32'h40628233, core_pkg::UNIT_ALU,    core_pkg::OP_SUB,    5'd4,  1'b1, 1'b0, 32'h0, 1'b0},
  '{32'h001473B3, core_pkg::UNIT_ALU,    core_pkg::OP_AND,    5'd7,  1'b1, 1'b0, 32'h0, 1'b0},
  '{32'h4041D133, core_pkg::UNIT_SHIFT,  core_pkg::OP_SRA,    5'd2,  1'b1, 1'b0, 32'h0, 1'b0},
  '{32'hFFB08293, core_pkg::UNIT_ALU,    core_pkg::OP_ADD,    5'd5,  1'b1, 1'b1, 32'hFFFFFFFB, 1'b0},
  '{32'h00711313, core_pkg::UNIT_SHIFT,  core_pkg::OP_SLL,    5'd6,  1'b1, 1'b1, 32'h7, 1'b0},
  '{32'h4033D093, core_pkg::UNIT_SHIFT,  core_pkg::OP_SRA,    5'd1,  1'b1, 1'b1, 32'h403, 1'b0},
  '{32'h0641B413, core_pkg::UNIT_ALU,    core_pkg::OP_SLTU,   5'd8,  1'b1, 1'b1, 32'd100, 1'b0},
  '{32'h00208863, core_pkg::UNIT_BRANCH, core_pkg::OP_BEQ,    5'd16, 1'b0, 1'b0, 32'd16, 1'b0},
  '{32'hFE62FCE3, core_pkg::UNIT_BRANCH, core_pkg::OP_BGEU,   5'd25, 1'b0, 1'b0, 32'hFFFFFFF8, 1'b0},
  '{32'h001000EF, core_pkg::UNIT_BRANCH, core_pkg::OP_JAL,    5'd1,  1'b1, 1'b1, 32'h800, 1'b0},
  '{32'h00408067, core_pkg::UNIT_BRANCH, core_pkg::OP_JALR,   5'd0,  1'b1, 1'b1, 32'h4, 1'b0},
  '{32'h00C1A103, core_pkg::UNIT_LSU,    core_pkg::OP_LOAD,   5'd2,  1'b1, 1'b1, 32'd12, 1'b0},
  '{32'hFFF2C203, core_pkg::UNIT_LSU,    core_pkg::OP_LOAD,   5'd4,  1'b1, 1'b1, 32'hFFFFFFFF, 1'b0},
  '{32'h0063AA23, core_pkg::UNIT_LSU,    core_pkg::OP_STORE,  5'd20, 1'b0, 1'b0, 32'd20, 1'b0},
  '{32'h022081B3, core_pkg::UNIT_MULDIV, core_pkg::OP_MUL,    5'd3,  1'b1, 1'b0, 32'h0, 1'b0},
  '{32'h0283D2B3, core_pkg::UNIT_MULDIV, core_pkg::OP_DIV,    5'd5,  1'b1, 1'b0, 32'h0, 1'b0},
  '{32'h300110F3, core_pkg::UNIT_SYSTEM, core_pkg::OP_CSR,    5'd1,  1'b1, 1'b1, 32'h300, 1'b0},
  '{32'h12345337, core_pkg::UNIT_ALU,    core_pkg::OP_LUI,    5'd6,  1'b1, 1'b1, 32'h12345000, 1'b0},
  '{32'hFFFFF397, core_pkg::UNIT_ALU,    core_pkg::OP_AUIPC,  5'd7,  1'b1, 1'b1, 32'hFFFFF000, 1'b0},
  '{32'h00000073, core_pkg::UNIT_SYSTEM, core_pkg::OP_ECALL,  5'd0,  1'b0, 1'b0, 32'h0, 1'b0},
  // Unknown opcode, then an OP word with a bad funct7
  '{32'h0020817F, core_pkg::UNIT_SYSTEM, core_pkg::OP_ECALL,  5'd2,  1'b0, 1'b0, 32'h0, 1'b1},
  '{32'h202081B3, core_pkg::UNIT_SYSTEM, core_pkg::OP_ECALL,  5'd3,  1'b0, 1'b0, 32'h0, 1'b1}
};

`endif

// File: test/frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

  localparam int unsigned CMP_W = $bits(core_pkg::issue_pkt_t);

  logic                 clk;
  logic                 rst;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [31:0]          wb_adr;
  logic [31:0]          wb_dat;
  logic                 wb_ack;
  logic                 rf_we;
  logic [4:0]           rf_waddr;
  logic [31:0]          rf_wdata;
  core_pkg::issue_pkt_t issue;
  logic                 out_valid;
  logic                 out_ready;
  logic                 preload_done;
  int unsigned          cycle_count;

  `include "frontend_tb_table.svh"

  // Generous per-row budget for wait states and random back-pressure
  localparam int unsigned TIMEOUT_CYCLES = NUM_ROWS * 20;

  frontend_top i_dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .wb_cyc_o    (wb_cyc),
    .wb_stb_o    (wb_stb),
    .wb_we_o     (wb_we),
    .wb_adr_o    (wb_adr),
    .wb_dat_i    (wb_dat),
    .wb_ack_i    (wb_ack),
    .rf_we_i     (rf_we),
    .rf_waddr_i  (rf_waddr),
    .rf_wdata_i  (rf_wdata),
    .issue_o     (issue),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  task automatic check_equal(input string name, input logic [CMP_W-1:0] got,
                             input logic [CMP_W-1:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // x0 reads as zero, x1..x8 hold the preload
  function automatic logic [31:0] reg_value(input logic [4:0] idx);
    if (idx == 5'd0) begin
      return 32'd0;
    end else begin
      return RF_INIT[idx];
    end
  endfunction

  // Past the end of the table the words follow the address
  function automatic logic [31:0] fetch_word(input logic [31:0] adr);
    logic [31:0] index;
    index = (adr - riscv_pkg::RESET_PC) >> 2;
    if (index < NUM_ROWS) begin
      return ROWS[index].instr;
    end else begin
      return adr ^ 32'h0000_0013;
    end
  endfunction

  task automatic check_packet(input int k, input core_pkg::issue_pkt_t pkt);
    row_t       row;
    logic [4:0] rs1_idx;
    logic [4:0] rs2_idx;
    row     = ROWS[k];
    rs1_idx = row.instr[19:15];
    rs2_idx = row.instr[24:20];
    check_equal("issue_o.pc", pkt.pc, riscv_pkg::RESET_PC + 32'(4 * k));
    check_equal("issue_o.dec.unit", pkt.dec.unit, row.unit);
    check_equal("issue_o.dec.op", pkt.dec.op, row.op);
    check_equal("issue_o.dec.rd", pkt.dec.rd, row.rd);
    check_equal("issue_o.dec.rd_v", pkt.dec.rd_v, row.rd_v);
    check_equal("issue_o.dec.op2_is_imm", pkt.dec.op2_is_imm, row.op2_is_imm);
    check_equal("issue_o.dec.imm", pkt.dec.imm, row.imm);
    check_equal("issue_o.dec.illegal", pkt.dec.illegal, row.illegal);
    if (row.illegal) begin
      check_equal("issue_o.dec.rs1_v", pkt.dec.rs1_v, 1'b0);
      check_equal("issue_o.dec.rs2_v", pkt.dec.rs2_v, 1'b0);
    end
    // Operands only where the source index was preloaded
    if (rs1_idx <= 5'd8) begin
      check_equal("issue_o.rs1_val", pkt.rs1_val, reg_value(rs1_idx));
    end
    if (row.op2_is_imm) begin
      check_equal("issue_o.op2_val", pkt.op2_val, row.imm);
    end else if (rs2_idx <= 5'd8) begin
      check_equal("issue_o.op2_val", pkt.op2_val, reg_value(rs2_idx));
    end
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin : timeout_counter
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles, not every packet came out", cycle_count);
        $display("Regression failed");
        $fatal(1, "Timeout");
      end
    end
  end

  // ----------------------------------------
  // Wishbone slave with random wait states
  // ----------------------------------------
  initial begin : memory_model
    int unsigned fetched;
    fetched = 0;
    wait (preload_done);
    forever begin
      @(posedge clk);
      #1;
      if (wb_cyc && wb_stb) begin
        check_equal("wb_adr_o", wb_adr, riscv_pkg::RESET_PC + 32'(4 * fetched));
        check_equal("wb_we_o", wb_we, 1'b0);
        repeat ($urandom_range(3, 0)) begin
          @(posedge clk);
          #1;
        end
        wb_dat = fetch_word(wb_adr);
        wb_ack = 1'b1;
        @(posedge clk);
        #1;
        wb_ack = 1'b0;
        fetched++;
      end
    end
  end

  initial begin : ready_driver
    wait (preload_done);
    forever begin
      @(posedge clk);
      #1;
      out_ready = $urandom_range(1, 0);
    end
  end

  // A stalled packet must hold until it is taken
  initial begin : hold_monitor
    core_pkg::issue_pkt_t held;
    logic                 stalled;
    stalled = 1'b0;
    held    = '0;
    forever begin
      @(negedge clk);
      if (stalled) begin
        check_equal("out_valid_o", out_valid, 1'b1);
        check_equal("issue_o", issue, held);
      end
      stalled = (out_valid === 1'b1) && (out_ready === 1'b0);
      held    = issue;
    end
  end

  // ----------------------------------------
  // Reset, preload and checker loop
  // ----------------------------------------
  initial begin : main_sequence
    void'($urandom(32'h59e1_1c55));
    rst          = 1'b1;
    rf_we        = 1'b0;
    rf_waddr     = 5'd0;
    rf_wdata     = 32'd0;
    wb_dat       = 32'd0;
    wb_ack       = 1'b0;
    out_ready    = 1'b0;
    preload_done = 1'b0;
    repeat (3) begin
      @(posedge clk);
      #1;
      check_equal("wb_cyc_o", wb_cyc, 1'b0);
      check_equal("wb_stb_o", wb_stb, 1'b0);
      check_equal("out_valid_o", out_valid, 1'b0);
    end
    rst = 1'b0;
    for (int i = 1; i <= 8; i++) begin
      rf_we    = 1'b1;
      rf_waddr = 5'(i);
      rf_wdata = RF_INIT[i];
      @(posedge clk);
      #1;
    end
    rf_we        = 1'b0;
    preload_done = 1'b1;
    for (int k = 0; k < NUM_ROWS; k++) begin
      @(negedge clk);
      while (!(out_valid && out_ready)) begin
        @(negedge clk);
      end
      check_packet(k, issue);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+test
hw/riscv_pkg.sv
hw/core_pkg.sv
hw/reg_file.sv
hw/decoder.sv
hw/fetch_stage.sv
hw/issue_stage.sv
hw/frontend_top.sv
test/frontend_tb.sv

// File: Bender.yml
package:
  name: rv32_frontend

sources:
  - files:
      - hw/riscv_pkg.sv
      - hw/core_pkg.sv
      - hw/reg_file.sv
      - hw/decoder.sv
      - hw/fetch_stage.sv
      - hw/issue_stage.sv
      - hw/frontend_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/frontend_tb.sv
